//--- common/spi_pkg.sv
package spi_pkg;

   // ---------------------------------------
   // SPI side data types
   // ---------------------------------------

   // One byte as it travels on MOSI or MISO
   typedef logic [7:0] spi_byte_t;

   // Receive FIFO entry
   // first marks the opening byte of a frame
   typedef struct packed {
      logic      first;
      spi_byte_t data;
   } rx_entry_t;

   // ---------------------------------------
   // Constants
   // ---------------------------------------

   // Byte returned on MISO while the host sends the first byte
   localparam spi_byte_t HEADER_DEFAULT = 8'hA7;

   // Value shifted out when no transmit data is ready
   localparam spi_byte_t UNDERRUN_BYTE = 8'h00;

endpackage

//--- common/bus_pkg.sv
package bus_pkg;

   // ---------------------------------------
   // Wishbone master states
   // ---------------------------------------

   // IDLE keeps cyc_o low for at least one clock between cycles
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      WRITE = 2'd1,
      READ  = 2'd2
   } bus_state_t;

   // ---------------------------------------
   // Address codes
   // ---------------------------------------

   // First byte of a frame is a command
   localparam logic ADR_COMMAND = 1'b0;
   // Remaining bytes and all reads
   localparam logic ADR_DATA = 1'b1;

endpackage

//--- spi/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter #(
   parameter spi_pkg::spi_byte_t HEADER_BYTE = spi_pkg::HEADER_DEFAULT
) (
   input  logic               sck_i,
   input  logic               ss_n_i,
   input  logic               mosi_i,
   input  spi_pkg::spi_byte_t tx_data_i,
   input  logic               tx_empty_i,
   input  logic               rx_full_i,
   output logic               miso_o,
   output spi_pkg::rx_entry_t rx_entry_o,
   output logic               rx_push_o,
   output logic               tx_pop_o,
   output logic               overflow_o,
   output logic               underrun_o
);

   import spi_pkg::*;

   // Receive side, rising sck_i
   logic [2:0] rx_cnt_q;
   logic [6:0] rx_shift_q;
   logic       first_q;
   logic       rx_done;

   // Transmit side, falling sck_i
   logic [2:0] tx_cnt_q;
   spi_byte_t  tx_shift_q;
   logic       tx_boundary;

   // ---------------------------------------
   // Receive path
   // ---------------------------------------

   // Eighth rising edge of a byte
   assign rx_done = (rx_cnt_q == 3'd7);

   // The last bit comes straight from the pin, so the FIFO
   // captures the whole byte on the edge that completes it
   assign rx_entry_o = '{first: first_q, data: {rx_shift_q, mosi_i}};
   assign rx_push_o  = rx_done && !rx_full_i;

   // Bit counter, cleared while deselected
   always_ff @(posedge sck_i or posedge ss_n_i) begin
      if (ss_n_i) begin
         rx_cnt_q <= 3'd0;
      end else begin
         rx_cnt_q <= rx_cnt_q + 3'd1;
      end
   end

   // MSB first deserializer
   always_ff @(posedge sck_i) begin
      rx_shift_q <= {rx_shift_q[5:0], mosi_i};
   end

   // First-of-frame tag, dropped once the first byte completes
   // Overflow is sticky until the host deselects
   always_ff @(posedge sck_i or posedge ss_n_i) begin
      if (ss_n_i) begin
         first_q    <= 1'b1;
         overflow_o <= 1'b0;
      end else if (rx_done) begin
         first_q <= 1'b0;
         // Full FIFO, this byte is lost
         if (rx_full_i) begin
            overflow_o <= 1'b1;
         end
      end
   end

   // ---------------------------------------
   // Transmit path
   // ---------------------------------------

   // Eighth falling edge, next byte goes out from here
   assign tx_boundary = (tx_cnt_q == 3'd7);
   assign miso_o      = tx_shift_q[7];

   // Header waits in the shifter while deselected so that its MSB
   // is on MISO before the first rising edge
   always_ff @(negedge sck_i or posedge ss_n_i) begin
      if (ss_n_i) begin
         tx_cnt_q   <= 3'd0;
         tx_shift_q <= HEADER_BYTE;
         tx_pop_o   <= 1'b0;
         underrun_o <= 1'b0;
      end else begin
         tx_cnt_q <= tx_cnt_q + 3'd1;
         // Pop is held for half a period and taken by the
         // FIFO on the next rising edge
         tx_pop_o <= tx_boundary && !tx_empty_i;
         if (tx_boundary) begin
            if (tx_empty_i) begin
               tx_shift_q <= UNDERRUN_BYTE;
               underrun_o <= 1'b1;
            end else begin
               tx_shift_q <= tx_data_i;
            end
         end else begin
            // MSB first
            tx_shift_q <= {tx_shift_q[6:0], 1'b0};
         end
      end
   end

endmodule

//--- spi/cdc_fifo.sv
`timescale 1ns/1ps

module cdc_fifo #(
   parameter type payload_t       = logic [7:0],
   parameter int  FIFO_DEPTH_LOG2 = 4
) (
   input  logic     wr_clk_i,
   input  logic     rd_clk_i,
   input  logic     rst_i,
   input  logic     wr_en_i,
   input  payload_t wr_data_i,
   input  logic     rd_en_i,
   output payload_t rd_data_o,
   output logic     empty_o,
   output logic     full_o
);

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
   // One extra bit tells a full FIFO from an empty one
   localparam int PW = FIFO_DEPTH_LOG2 + 1;
   // Full when the two top Gray bits differ and the rest match
   localparam logic [PW-1:0] FULL_MASK = PW'(3) << (PW - 2);

   payload_t mem_q [DEPTH];

   // Write domain
   logic [PW-1:0] wr_bin_q;
   logic [PW-1:0] wr_gray_q;
   logic [PW-1:0] wr_bin_next;
   logic [PW-1:0] rd_gray_w1_q;
   logic [PW-1:0] rd_gray_w2_q;
   logic          wr_fire;

   // Read domain
   logic [PW-1:0] rd_bin_q;
   logic [PW-1:0] rd_gray_q;
   logic [PW-1:0] rd_bin_next;
   logic [PW-1:0] wr_gray_r1_q;
   logic [PW-1:0] wr_gray_r2_q;
   logic          rd_fire;

   // ---------------------------------------
   // Write side
   // ---------------------------------------

   assign wr_fire     = wr_en_i && !full_o;
   assign wr_bin_next = wr_bin_q + PW'(wr_fire);
   assign full_o      = (wr_gray_q == (rd_gray_w2_q ^ FULL_MASK));

   always_ff @(posedge wr_clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_bin_q     <= '0;
         wr_gray_q    <= '0;
         rd_gray_w1_q <= '0;
         rd_gray_w2_q <= '0;
      end else begin
         wr_bin_q     <= wr_bin_next;
         wr_gray_q    <= wr_bin_next ^ (wr_bin_next >> 1);
         // Two-flop synchronizer for the read pointer
         rd_gray_w1_q <= rd_gray_q;
         rd_gray_w2_q <= rd_gray_w1_q;
      end
   end

   // Storage
   always_ff @(posedge wr_clk_i) begin
      if (wr_fire) begin
         mem_q[wr_bin_q[FIFO_DEPTH_LOG2-1:0]] <= wr_data_i;
      end
   end

   // ---------------------------------------
   // Read side
   // ---------------------------------------

   assign rd_fire     = rd_en_i && !empty_o;
   assign rd_bin_next = rd_bin_q + PW'(rd_fire);
   // Empty until the write pointer has crossed both sync flops
   assign empty_o     = (rd_gray_q == wr_gray_r2_q);
   // Head entry, valid whenever empty_o is low
   assign rd_data_o   = mem_q[rd_bin_q[FIFO_DEPTH_LOG2-1:0]];

   always_ff @(posedge rd_clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_bin_q     <= '0;
         rd_gray_q    <= '0;
         wr_gray_r1_q <= '0;
         wr_gray_r2_q <= '0;
      end else begin
         rd_bin_q     <= rd_bin_next;
         rd_gray_q    <= rd_bin_next ^ (rd_bin_next >> 1);
         // Two-flop synchronizer for the write pointer
         wr_gray_r1_q <= wr_gray_q;
         wr_gray_r2_q <= wr_gray_r1_q;
      end
   end

endmodule

//--- hw/bus_timeout_timer.sv
`timescale 1ns/1ps

module bus_timeout_timer #(
   parameter int TIMEOUT_CYCLES = 16
) (
   input  logic clk_i,
   input  logic SSEL,
   input  logic stb_i,
   input  logic ack_i,
   output logic expired_o
);

   localparam int CW = $clog2(TIMEOUT_CYCLES + 1);

   // Strobe cycles already waited without ack
   logic [CW-1:0] cnt_q;

   // The current cycle is number cnt_q + 1, so expiry falls on
   // the TIMEOUT_CYCLES-th clock of the strobe
   assign expired_o = stb_i && !ack_i && (cnt_q == CW'(TIMEOUT_CYCLES - 1));

   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         cnt_q <= '0;
      end else if (!stb_i || ack_i || expired_o) begin
         // Restart for the next cycle, expiry stays one clock wide
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + CW'(1);
      end
   end

endmodule

//--- hw/bus_master_fsm.sv
`timescale 1ns/1ps

module bus_master_fsm (
   input  logic               clk_i,
   input  logic               SSEL,
   input  logic               ss_n_i,
   input  spi_pkg::rx_entry_t rx_entry_i,
   input  logic               rx_empty_i,
   input  logic               ack_i,
   input  spi_pkg::spi_byte_t dat_i,
   input  logic               expired_i,
   output logic               rx_pop_o,
   output logic               tx_push_o,
   output spi_pkg::spi_byte_t tx_data_o,
   output logic               cyc_o,
   output logic               stb_o,
   output logic               we_o,
   output logic               adr_o,
   output spi_pkg::spi_byte_t dat_o,
   output logic               bus_error_o
);

   import bus_pkg::*;

   bus_state_t state_q;

   // Chip select brought into the clk_i domain
   logic ss_meta_q;
   logic ss_sync_q;
   logic sel_q;
   logic sel;
   logic frame_start;

   // One read owed to the transmit FIFO
   logic rd_pend_q;
   logic start_read;
   logic cycle_end;

   // ---------------------------------------
   // Frame detection
   // ---------------------------------------

   assign sel         = !ss_sync_q;
   assign frame_start = sel && !sel_q;

   // Deselected out of reset
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         ss_meta_q <= 1'b1;
         ss_sync_q <= 1'b1;
         sel_q     <= 1'b0;
      end else begin
         ss_meta_q <= ss_n_i;
         ss_sync_q <= ss_meta_q;
         sel_q     <= sel;
      end
   end

   // ---------------------------------------
   // Cycle control
   // ---------------------------------------

   // Expiry ends the cycle the same way as ack
   assign cycle_end  = (state_q != IDLE) && (ack_i || expired_i);
   // A pending read goes first, keeping the write then read order
   assign start_read = (state_q == IDLE) && rd_pend_q;
   assign rx_pop_o   = (state_q == IDLE) && !rx_empty_i && !rd_pend_q;
   // Read data is only kept when the slave really acknowledged
   assign tx_push_o  = (state_q == READ) && ack_i;
   assign tx_data_o  = dat_i;

   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         state_q <= IDLE;
         cyc_o   <= 1'b0;
         stb_o   <= 1'b0;
         we_o    <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (start_read) begin
                  state_q <= READ;
                  cyc_o   <= 1'b1;
                  stb_o   <= 1'b1;
                  we_o    <= 1'b0;
               end else if (rx_pop_o) begin
                  state_q <= WRITE;
                  cyc_o   <= 1'b1;
                  stb_o   <= 1'b1;
                  we_o    <= 1'b1;
               end
            end
            WRITE, READ: begin
               // Drop the strobe in the clock after ack or expiry
               if (cycle_end) begin
                  state_q <= IDLE;
                  cyc_o   <= 1'b0;
                  stb_o   <= 1'b0;
                  we_o    <= 1'b0;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Read request bookkeeping and sticky bus error
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         rd_pend_q   <= 1'b0;
         bus_error_o <= 1'b0;
      end else begin
         if (!sel) begin
            rd_pend_q <= 1'b0;
         end else if (frame_start) begin
            rd_pend_q <= 1'b1;
         end else if (start_read) begin
            rd_pend_q <= 1'b0;
         end else if ((state_q == WRITE) && cycle_end) begin
            rd_pend_q <= 1'b1;
         end
         if (cycle_end && expired_i && !ack_i) begin
            bus_error_o <= 1'b1;
         end
      end
   end

   // Address and write data, held for the whole cycle
   always_ff @(posedge clk_i) begin
      if (rx_pop_o) begin
         adr_o <= rx_entry_i.first ? ADR_COMMAND : ADR_DATA;
         dat_o <= rx_entry_i.data;
      end else if (start_read) begin
         adr_o <= ADR_DATA;
      end
   end

endmodule

//--- hw/spi_target_top.sv
`timescale 1ns/1ps

module spi_target_top #(
   parameter spi_pkg::spi_byte_t HEADER_BYTE     = spi_pkg::HEADER_DEFAULT,
   parameter int                 FIFO_DEPTH_LOG2 = 4,
   parameter int                 TIMEOUT_CYCLES  = 16
) (
   input  logic               clk_i,
   input  logic               SSEL,
   input  logic               sck_i,
   input  logic               ss_n_i,
   input  logic               mosi_i,
   input  logic               ack_i,
   input  spi_pkg::spi_byte_t dat_i,
   output logic               miso_o,
   output logic               cyc_o,
   output logic               stb_o,
   output logic               we_o,
   output logic               adr_o,
   output spi_pkg::spi_byte_t dat_o,
   output logic               overflow_o,
   output logic               underrun_o,
   output logic               bus_error_o
);

   import spi_pkg::*;

   // ---------------------------------------
   // Receive path from sck_i to clk_i
   // ---------------------------------------
   rx_entry_t rx_wr_entry;
   rx_entry_t rx_rd_entry;
   logic      rx_push;
   logic      rx_pop;
   logic      rx_empty;
   logic      rx_full;

   // ---------------------------------------
   // Transmit path from clk_i to sck_i
   // ---------------------------------------
   spi_byte_t tx_wr_data;
   spi_byte_t tx_rd_data;
   logic      tx_push;
   logic      tx_pop;
   logic      tx_empty;
   logic      tx_fifo_rst;

   // Bus timeout
   logic      expired;

   // Leftover prefetch is dropped whenever the host deselects
   assign tx_fifo_rst = SSEL | ss_n_i;

   spi_shifter #(
      .HEADER_BYTE (HEADER_BYTE)
   ) shifter_i (
      .sck_i      (sck_i),
      .ss_n_i     (ss_n_i),
      .mosi_i     (mosi_i),
      .tx_data_i  (tx_rd_data),
      .tx_empty_i (tx_empty),
      .rx_full_i  (rx_full),
      .miso_o     (miso_o),
      .rx_entry_o (rx_wr_entry),
      .rx_push_o  (rx_push),
      .tx_pop_o   (tx_pop),
      .overflow_o (overflow_o),
      .underrun_o (underrun_o)
   );

   // Received bytes with their first-of-frame tag
   cdc_fifo #(
      .payload_t       (rx_entry_t),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) rx_fifo_i (
      .wr_clk_i  (sck_i),
      .rd_clk_i  (clk_i),
      .rst_i     (SSEL),
      .wr_en_i   (rx_push),
      .wr_data_i (rx_wr_entry),
      .rd_en_i   (rx_pop),
      .rd_data_o (rx_rd_entry),
      .empty_o   (rx_empty),
      .full_o    (rx_full)
   );

   // Prefetched MISO bytes
   cdc_fifo #(
      .payload_t       (spi_byte_t),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) tx_fifo_i (
      .wr_clk_i  (clk_i),
      .rd_clk_i  (sck_i),
      .rst_i     (tx_fifo_rst),
      .wr_en_i   (tx_push),
      .wr_data_i (tx_wr_data),
      .rd_en_i   (tx_pop),
      .rd_data_o (tx_rd_data),
      .empty_o   (tx_empty),
      .full_o    ()
   );

   bus_master_fsm fsm_i (
      .clk_i       (clk_i),
      .SSEL        (SSEL),
      .ss_n_i      (ss_n_i),
      .rx_entry_i  (rx_rd_entry),
      .rx_empty_i  (rx_empty),
      .ack_i       (ack_i),
      .dat_i       (dat_i),
      .expired_i   (expired),
      .rx_pop_o    (rx_pop),
      .tx_push_o   (tx_push),
      .tx_data_o   (tx_wr_data),
      .cyc_o       (cyc_o),
      .stb_o       (stb_o),
      .we_o        (we_o),
      .adr_o       (adr_o),
      .dat_o       (dat_o),
      .bus_error_o (bus_error_o)
   );

   bus_timeout_timer #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) timer_i (
      .clk_i     (clk_i),
      .SSEL      (SSEL),
      .stb_i     (stb_o),
      .ack_i     (ack_i),
      .expired_o (expired)
   );

endmodule

//--- bench/spi_target_checker.sv
`timescale 1ns/1ps

module spi_target_checker #(
   parameter int TIMEOUT_CYCLES = 16
) (
   input logic                   clk_i,
   input logic                   SSEL,
   input logic                   cyc_i,
   input logic                   stb_i,
   input logic                   we_i,
   input logic                   adr_i,
   input logic [7:0]             dat_i,
   input logic                   ack_i,
   input bus_pkg::bus_state_t    state_i
);

   import bus_pkg::*;

   // Clocks the FSM has spent in the current cycle
   int open_cnt_q;

   // ---------------------------------------
   // Reset state
   // ---------------------------------------

   // Bus is quiet on the first clock after reset release
   reset_quiet: assert property (@(posedge clk_i)
      $fell(SSEL) |-> !cyc_i && !stb_i && !we_i)
      else $error("bus outputs active after reset");

   // ---------------------------------------
   // Wishbone classic protocol
   // ---------------------------------------

   // No strobe outside a cycle
   stb_in_cyc: assert property (@(posedge clk_i) disable iff (SSEL)
      stb_i |-> cyc_i)
      else $error("stb without cyc");

   // Address and data held until the slave answers or the timer fires
   hold_stable: assert property (@(posedge clk_i) disable iff (SSEL)
      stb_i && !ack_i |=> !stb_i || ($stable(adr_i) && $stable(we_i) && $stable(dat_i)))
      else $error("bus signals changed during a cycle");

   // Cycle closes one clock after ack
   end_after_ack: assert property (@(posedge clk_i) disable iff (SSEL)
      cyc_i && ack_i |=> !cyc_i && !stb_i)
      else $error("cycle still open after ack");

   // ---------------------------------------
   // Bus timeout
   // ---------------------------------------

   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         open_cnt_q <= 0;
      end else if (state_i == IDLE) begin
         open_cnt_q <= 0;
      end else begin
         open_cnt_q <= open_cnt_q + 1;
      end
   end

   // An unanswered cycle is closed by the timer
   cycle_bounded: assert property (@(posedge clk_i) disable iff (SSEL)
      open_cnt_q <= TIMEOUT_CYCLES)
      else $error("bus cycle open longer than the timeout");

endmodule

bind spi_target_top spi_target_checker #(
   .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
) checker_i (
   .clk_i   (clk_i),
   .SSEL    (SSEL),
   .cyc_i   (cyc_o),
   .stb_i   (stb_o),
   .we_i    (we_o),
   .adr_i   (adr_o),
   .dat_i   (dat_o),
   .ack_i   (ack_i),
   .state_i (fsm_i.state_q)
);

//--- bench/spi_target_tb.sv
`timescale 1ns/1ps

module spi_target_tb;

   import spi_pkg::*;
   import bus_pkg::*;

   logic      clk_i;
   logic      SSEL;
   logic      sck_i;
   logic      ss_n_i;
   logic      mosi_i;
   logic      ack_i;
   spi_byte_t dat_i;
   logic      miso_o;
   logic      cyc_o;
   logic      stb_o;
   logic      we_o;
   logic      adr_o;
   spi_byte_t dat_o;
   logic      overflow_o;
   logic      underrun_o;
   logic      bus_error_o;

   integer    seed;
   // Slave read counter holding the next value handed out
   spi_byte_t rd_count;
   // Reads acked in the current frame
   spi_byte_t read_q[$];
   // Bytes the bus should see, in order
   rx_entry_t write_q[$];
   // Bytes captured from MISO in the current frame
   spi_byte_t miso_q[$];
   logic      in_cycle;
   logic      hold_once;
   logic      hold_all;
   logic      check_writes;

   spi_target_top dut_i (.*);

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // ---------------------------------------
   // Failure reporting
   // ---------------------------------------

   task automatic fail_value(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic fail_timeout(input string what);
      $display("Timed out waiting for %s", what);
      $display("Testbench failed");
      $fatal(1);
   endtask

   // ---------------------------------------
   // Wishbone slave model
   // ---------------------------------------

   always @(posedge clk_i) begin
      rx_entry_t exp;
      if (!stb_o) in_cycle = 1'b0;
      if (ack_i) begin
         ack_i <= 1'b0;
      end else if (stb_o && !in_cycle) begin
         in_cycle = 1'b1;
         // Write contents checked when the strobe first shows up
         if (we_o && check_writes) begin
            assert (write_q.size() > 0) else fail_value("unexpected bus write");
            exp = write_q.pop_front();
            assert (dat_o == exp.data)
               else fail_value($sformatf("write data %h, expected %h", dat_o, exp.data));
            assert (adr_o == (exp.first ? ADR_COMMAND : ADR_DATA))
               else fail_value($sformatf("write address %b for byte %h", adr_o, exp.data));
         end
         if (hold_all || (hold_once && we_o)) begin
            // No ack so the timer has to end this one
            hold_once = 1'b0;
         end else begin
            ack_i <= 1'b1;
            if (!we_o) begin
               dat_i <= rd_count;
               read_q.push_back(rd_count);
               rd_count = rd_count + 8'd1;
            end
         end
      end
   end

   // ---------------------------------------
   // SPI host model in mode 0
   // ---------------------------------------

   // half is the number of clk_i cycles per sck_i phase
   task automatic xfer_byte(input spi_byte_t tx, input int half, output spi_byte_t rx);
      for (int i = 7; i >= 0; i--) begin
         mosi_i <= tx[i];
         repeat (half) @(posedge clk_i);
         // MISO settled since the last falling edge
         rx[i] = miso_o;
         sck_i <= 1'b1;
         repeat (half) @(posedge clk_i);
         sck_i <= 1'b0;
      end
   endtask

   // Selects the DUT and clocks n random bytes and leaves it selected
   task automatic run_frame(input int n, input int half);
      spi_byte_t b;
      spi_byte_t rx;
      rx_entry_t entry;
      read_q.delete();
      miso_q.delete();
      @(posedge clk_i);
      ss_n_i <= 1'b0;
      repeat (half) @(posedge clk_i);
      for (int k = 0; k < n; k++) begin
         b = 8'($random(seed));
         entry.first = (k == 0);
         entry.data  = b;
         if (check_writes) write_q.push_back(entry);
         xfer_byte(b, half, rx);
         miso_q.push_back(rx);
      end
      repeat (half) @(posedge clk_i);
   endtask

   task automatic wait_bus_idle(input int limit);
      int quiet;
      int t;
      quiet = 0;
      t = 0;
      while (quiet < 40) begin
         @(posedge clk_i);
         quiet = cyc_o ? 0 : quiet + 1;
         t++;
         if (t > limit) fail_timeout("the bus to go idle");
      end
   endtask

   task automatic end_frame();
      ss_n_i <= 1'b1;
      wait_bus_idle(2000);
      assert (write_q.size() == 0)
         else fail_value($sformatf("%0d bus writes missing", write_q.size()));
   endtask

   // Header first and then the frame's reads in counter order
   task automatic check_miso(input int n);
      assert (miso_q[0] == HEADER_DEFAULT)
         else fail_value($sformatf("MISO byte 0 is %h, expected header", miso_q[0]));
      assert (read_q.size() >= n - 1) else fail_value("too few bus reads in frame");
      for (int k = 1; k < n; k++) begin
         assert (miso_q[k] == read_q[k-1])
            else fail_value($sformatf("MISO byte %0d is %h, expected %h",
                                      k, miso_q[k], read_q[k-1]));
      end
   endtask

   // ---------------------------------------
   // Test sequence
   // ---------------------------------------

   initial begin
      SSEL         = 1'b1;
      sck_i        = 1'b0;
      ss_n_i       = 1'b1;
      mosi_i       = 1'b0;
      ack_i        = 1'b0;
      dat_i        = 8'h00;
      seed         = 17;
      rd_count     = 8'h30;
      in_cycle     = 1'b0;
      hold_once    = 1'b0;
      hold_all     = 1'b0;
      check_writes = 1'b1;
      repeat (4) @(posedge clk_i);
      SSEL <= 1'b0;

      // Bus stays quiet while deselected
      repeat (60) begin
         @(posedge clk_i);
         assert (!cyc_o) else fail_value("bus cycle while deselected");
      end
      assert (!overflow_o && !underrun_o && !bus_error_o)
         else fail_value("status flag set after reset");

      // Writes in order and MISO header then reads
      run_frame(4, 10);
      end_frame();
      check_miso(4);

      // Prefetch from the previous frame is gone
      run_frame(3, 10);
      end_frame();
      check_miso(3);

      // Unanswered write followed by a normal frame
      hold_once = 1'b1;
      run_frame(3, 10);
      end_frame();
      assert (bus_error_o) else fail_value("bus_error_o not set after timeout");
      check_miso(3);
      run_frame(2, 10);
      end_frame();
      check_miso(2);

      // Fast bytes against a stalled bus
      check_writes = 1'b0;
      hold_all     = 1'b1;
      run_frame(48, 1);
      assert (overflow_o) else fail_value("overflow_o not set");
      assert (underrun_o) else fail_value("underrun_o not set");
      assert (miso_q[0] == HEADER_DEFAULT) else fail_value("fast frame header wrong");
      assert (miso_q[1] == UNDERRUN_BYTE)
         else fail_value($sformatf("MISO byte 1 is %h on underrun", miso_q[1]));
      hold_all = 1'b0;
      ss_n_i <= 1'b1;
      wait_bus_idle(5000);
      check_writes = 1'b1;

      // Recovers after the overflow
      run_frame(2, 10);
      end_frame();
      check_miso(2);

      $display("Testbench passed");
      $finish;
   end

endmodule

//--- list.f
common/spi_pkg.sv
common/bus_pkg.sv
spi/spi_shifter.sv
spi/cdc_fifo.sv
hw/bus_timeout_timer.sv
hw/bus_master_fsm.sv
hw/spi_target_top.sv
bench/spi_target_checker.sv
bench/spi_target_tb.sv

//--- Makefile
TOP := spi_target_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
